// ==== sources.f ====
+incdir+include
source/mem_op_pkg.sv
source/dcache_pkg.sv
source/line_sram.sv
source/dcache_ctrl.sv
source/main_mem_ctrl.sv
source/dcache_top.sv
test/tb_dcache.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_dcache
SEED     ?= 28
FLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST ?= sources.f
OBJ_DIR  ?= obj_dir

SRCS := $(wildcard include/*.svh source/*.sv test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulation binary is the pass or fail result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ns

`include "dcache_config.svh"

module tb_dcache
    import mem_op_pkg::*;
#(
    parameter int SEED = 28
);

    localparam int NUM_DIRECTED   = 48;
    localparam int NUM_RANDOM     = 400;
    localparam int TIMEOUT_CYCLES =
        (NUM_DIRECTED + NUM_RANDOM) * (2 * `MM_LATENCY + 4) + 200;

    logic        clk_i;
    logic        rst_i;
    logic        read_i;
    logic        write_i;
    logic [31:0] addr_i;
    logic [31:0] wdata_i;
    mem_op_e     op_i;
    logic [31:0] rdata_o;
    logic        done_o;

    // byte image of the 64 KiB backing memory
    logic [7:0]  ref_mem [0:65535];
    logic [31:0] expected;
    int          cycle_cnt;

    dcache_top i_dcache_top (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .read_i  (read_i),
        .write_i (write_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .op_i    (op_i),
        .rdata_o (rdata_o),
        .done_o  (done_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] load_ref(input mem_op_e op, input logic [31:0] addr);
        logic [15:0] a;
        logic [15:0] h;
        logic [31:0] w;
        a = addr[15:0];
        h = {ref_mem[a + 16'd1], ref_mem[a]};
        w = {ref_mem[a + 16'd3], ref_mem[a + 16'd2], h};
        case (op)
            OP_LB:   load_ref = {{24{ref_mem[a][7]}}, ref_mem[a]};
            OP_LBU:  load_ref = {24'd0, ref_mem[a]};
            OP_LH:   load_ref = {{16{h[15]}}, h};
            OP_LHU:  load_ref = {16'd0, h};
            OP_LW:   load_ref = w;
            default: load_ref = 32'd0;
        endcase
    endfunction

    task automatic store_ref(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        logic [15:0] a;
        a = addr[15:0];
        ref_mem[a] = data[7:0];
        if (op != OP_SB) begin
            ref_mem[a + 16'd1] = data[15:8];
        end
        if (op == OP_SW) begin
            ref_mem[a + 16'd2] = data[23:16];
            ref_mem[a + 16'd3] = data[31:24];
        end
    endtask

    // natural alignment inside the 64 KiB window
    function automatic logic [31:0] align_addr(input mem_op_e op, input logic [31:0] raw);
        logic [31:0] a;
        a = {16'd0, raw[15:0]};
        if (op inside {OP_LW, OP_SW}) begin
            a[1:0] = 2'b00;
        end else if (op inside {OP_LH, OP_LHU, OP_SH}) begin
            a[0] = 1'b0;
        end
        align_addr = a;
    endfunction

    task automatic do_access(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data, output int cycles);
        @(posedge clk_i);
        #1;
        write_i = op inside {OP_SB, OP_SH, OP_SW};
        read_i  = !write_i;
        addr_i  = addr;
        wdata_i = data;
        op_i    = op;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!done_o);
    endtask

    task automatic load_word_bytes(input logic [31:0] base);
        int lat;
        for (int k = 0; k < 4; k++) begin
            do_access(OP_LB, base + 32'(k), 32'd0, lat);
            do_access(OP_LBU, base + 32'(k), 32'd0, lat);
        end
        for (int k = 0; k < 4; k += 2) begin
            do_access(OP_LH, base + 32'(k), 32'd0, lat);
            do_access(OP_LHU, base + 32'(k), 32'd0, lat);
        end
        do_access(OP_LW, base, 32'd0, lat);
    endtask

    // outputs are compared mid-cycle, after inputs and state have settled
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (done_o && read_i) begin
                expected = load_ref(op_i, addr_i);
                assert (rdata_o == expected) else
                    fail_now($sformatf("mismatch at %0t ns: %s @%h read %h, expected %h",
                                       $time, op_i.name(), addr_i, rdata_o, expected));
            end else begin
                assert (rdata_o == 32'd0) else
                    fail_now($sformatf("mismatch at %0t ns: rdata %h outside a load done",
                                       $time, rdata_o));
            end
            if (done_o && write_i) begin
                store_ref(op_i, addr_i, wdata_i);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout: accesses did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    initial begin
        logic [31:0] rnd;
        mem_op_e     op;
        int          lat;
        rnd           = $urandom(SEED);
        clk_i         = 1'b0;
        rst_i         = 1'b0;
        read_i        = 1'b0;
        write_i       = 1'b0;
        addr_i        = 32'd0;
        wdata_i       = 32'd0;
        op_i          = OP_LB;
        cycle_cnt     = 0;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = 8'd0;
        end
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        // cold miss of every load type, then a hit on the same line
        for (int k = 0; k < 5; k++) begin
            op = mem_op_e'(k[2:0]);
            do_access(op, align_addr(op, 32'h1005 + 32'(k * 16)), 32'd0, lat);
            assert (lat == 2 + `MM_LATENCY) else
                fail_now($sformatf("mismatch at %0t ns: cold miss took %0d cycles",
                                   $time, lat));
            do_access(op, align_addr(op, 32'h1005 + 32'(k * 16)), 32'd0, lat);
            assert (lat == 2) else
                fail_now($sformatf("mismatch at %0t ns: hit took %0d cycles", $time, lat));
        end

        // every store width, then every load extension
        do_access(OP_SW, 32'h0200, 32'h8bad_f00d, lat);
        load_word_bytes(32'h0200);
        do_access(OP_SB, 32'h0205, 32'h0000_00f0, lat);
        do_access(OP_SH, 32'h0206, 32'h0000_8001, lat);
        do_access(OP_SB, 32'h0204, 32'h0000_007f, lat);
        load_word_bytes(32'h0204);

        // store miss allocates, rest of the line stays zero
        do_access(OP_SH, 32'h3006, 32'h0000_beef, lat);
        for (int k = 0; k < 16; k += 4) begin
            do_access(OP_LW, 32'h3000 + 32'(k), 32'd0, lat);
        end

        // dirty victim at index of 0x440 must reach memory
        do_access(OP_SW, 32'h0440, 32'h1234_5678, lat);
        do_access(OP_LW, 32'h0c40, 32'd0, lat);
        do_access(OP_LW, 32'h0440, 32'd0, lat);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $urandom;
            op  = mem_op_e'(rnd[2:0]);
            do_access(op, align_addr(op, $urandom), $urandom, lat);
        end

        @(posedge clk_i);
        #1;
        read_i  = 1'b0;
        write_i = 1'b0;
        repeat (2) @(posedge clk_i);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ns

`include "dcache_config.svh"

module dcache_top
    import mem_op_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  mem_op_e     op_i,
    output logic [31:0] rdata_o,
    output logic        done_o
);

    logic                      sram_en;
    logic                      sram_we;
    logic [`DC_INDEX_BITS-1:0] sram_addr;
    logic [`DC_ENTRY_BITS-1:0] sram_wentry;
    logic [`DC_ENTRY_BITS-1:0] sram_rentry;

    logic                      mem_free;
    logic                      mem_ready;
    logic [`DC_LINE_BITS-1:0]  mem_rline;
    logic                      mem_req;
    logic                      mem_wr;
    logic                      mem_rd;
    logic [31:0]               mem_addr;
    logic [`DC_LINE_BITS-1:0]  mem_wline;

    dcache_ctrl i_dcache_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .read_i        (read_i),
        .write_i       (write_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .op_i          (op_i),
        .rdata_o       (rdata_o),
        .done_o        (done_o),
        .sram_en_o     (sram_en),
        .sram_we_o     (sram_we),
        .sram_addr_o   (sram_addr),
        .sram_wentry_o (sram_wentry),
        .sram_rentry_i (sram_rentry),
        .mem_free_i    (mem_free),
        .mem_ready_i   (mem_ready),
        .mem_rline_i   (mem_rline),
        .mem_req_o     (mem_req),
        .mem_wr_o      (mem_wr),
        .mem_rd_o      (mem_rd),
        .mem_addr_o    (mem_addr),
        .mem_wline_o   (mem_wline)
    );

    line_sram i_line_sram (
        .clk_i    (clk_i),
        .en_i     (sram_en),
        .we_i     (sram_we),
        .addr_i   (sram_addr),
        .wentry_i (sram_wentry),
        .rentry_o (sram_rentry)
    );

    main_mem_ctrl i_main_mem_ctrl (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (mem_req),
        .wr_i    (mem_wr),
        .rd_i    (mem_rd),
        .addr_i  (mem_addr),
        .wline_i (mem_wline),
        .free_o  (mem_free),
        .ready_o (mem_ready),
        .rline_o (mem_rline)
    );

endmodule

// ==== source/main_mem_ctrl.sv ====
`timescale 1ns/1ns

`include "dcache_config.svh"

module main_mem_ctrl
    import dcache_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      req_i,
    input  logic                      wr_i,
    input  logic                      rd_i,
    input  logic [31:0]               addr_i,
    input  logic [`DC_LINE_BITS-1:0]  wline_i,
    output logic                      free_o,
    output logic                      ready_o,
    output logic [`DC_LINE_BITS-1:0]  rline_o
);

    localparam int ADDR_BITS = $clog2(`MM_LINES);
    localparam int CNT_BITS  = $clog2(`MM_LATENCY);

    mm_state_e state_q;
    mm_state_e state_d;

    logic [CNT_BITS-1:0]      cnt_q;
    logic                     last;
    logic                     accept;
    logic                     wr_q;
    logic                     rd_q;
    logic [ADDR_BITS-1:0]     addr_q;
    logic [`DC_LINE_BITS-1:0] wline_q;
    logic [`DC_LINE_BITS-1:0] rline_q;

    logic [`DC_LINE_BITS-1:0] mem_q [`MM_LINES];

    initial begin
        for (int i = 0; i < `MM_LINES; i++) begin
            mem_q[i] = '0;
        end
    end

    // a new request is taken in the ready cycle too
    assign free_o  = (state_q != MM_BUSY);
    assign ready_o = (state_q == MM_DONE);
    assign rline_o = rline_q;
    assign accept  = req_i && free_o;
    assign last    = (cnt_q == CNT_BITS'(`MM_LATENCY - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            MM_FREE: if (req_i) state_d = MM_BUSY;
            MM_BUSY: if (last) state_d = MM_DONE;
            MM_DONE: state_d = req_i ? MM_BUSY : MM_FREE;
            default: state_d = MM_FREE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= MM_FREE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cnt_q <= CNT_BITS'(1);
            end else if (state_q == MM_BUSY) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wr_q    <= wr_i;
            rd_q    <= rd_i;
            addr_q  <= addr_i[4 +: ADDR_BITS];
            wline_q <= wline_i;
        end
        // read lands on the ready cycle, write commits in it
        if (state_q == MM_BUSY && last && rd_q) begin
            rline_q <= mem_q[addr_q];
        end
        if (state_q == MM_DONE && wr_q) begin
            mem_q[addr_q] <= wline_q;
        end
    end

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_i |-> (state_q != MM_BUSY));

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ns

`include "dcache_config.svh"

module dcache_ctrl
    import mem_op_pkg::*;
    import dcache_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,

    // memory stage
    input  logic                       read_i,
    input  logic                       write_i,
    input  logic [31:0]                addr_i,
    input  logic [31:0]                wdata_i,
    input  mem_op_e                    op_i,
    output logic [31:0]                rdata_o,
    output logic                       done_o,

    // line ram
    output logic                       sram_en_o,
    output logic                       sram_we_o,
    output logic [`DC_INDEX_BITS-1:0]  sram_addr_o,
    output logic [`DC_ENTRY_BITS-1:0]  sram_wentry_o,
    input  logic [`DC_ENTRY_BITS-1:0]  sram_rentry_i,

    // backing memory controller
    input  logic                       mem_free_i,
    input  logic                       mem_ready_i,
    input  logic [`DC_LINE_BITS-1:0]   mem_rline_i,
    output logic                       mem_req_o,
    output logic                       mem_wr_o,
    output logic                       mem_rd_o,
    output logic [31:0]                mem_addr_o,
    output logic [`DC_LINE_BITS-1:0]   mem_wline_o
);

    dc_state_e state_q;
    dc_state_e state_d;

    logic [`DC_LINES-1:0] valid_q;
    logic [`DC_LINES-1:0] dirty_q;

    logic [`DC_INDEX_BITS-1:0] index;
    logic [`DC_TAG_BITS-1:0]   tag;
    logic [3:0]                offset;
    logic [`DC_TAG_BITS-1:0]   way_tag;
    logic [`DC_LINE_BITS-1:0]  way_line;
    logic [`DC_LINE_BITS-1:0]  fill_line;
    logic [31:0]               line_addr;
    logic [31:0]               victim_addr;
    logic                      hit;
    logic                      victim_dirty;
    logic                      fill_en;
    logic                      store_hit;

    // sign or zero extend the addressed byte, half or word
    function automatic logic [31:0] load_ext(
        input logic [`DC_LINE_BITS-1:0] line,
        input logic [3:0]               off,
        input mem_op_e                  op
    );
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = line[{off, 3'b000} +: 8];
        h = line[{off[3:1], 4'b0000} +: 16];
        w = line[{off[3:2], 5'b00000} +: 32];
        case (op)
            OP_LB:   load_ext = {{24{b[7]}}, b};
            OP_LH:   load_ext = {{16{h[15]}}, h};
            OP_LW:   load_ext = w;
            OP_LBU:  load_ext = {24'd0, b};
            OP_LHU:  load_ext = {16'd0, h};
            default: load_ext = 32'd0;
        endcase
    endfunction

    function automatic logic [`DC_LINE_BITS-1:0] store_merge(
        input logic [`DC_LINE_BITS-1:0] line,
        input logic [3:0]               off,
        input logic [31:0]              data,
        input mem_op_e                  op
    );
        store_merge = line;
        case (op)
            OP_SB:   store_merge[{off, 3'b000} +: 8] = data[7:0];
            OP_SH:   store_merge[{off[3:1], 4'b0000} +: 16] = data[15:0];
            OP_SW:   store_merge[{off[3:2], 5'b00000} +: 32] = data;
            default: store_merge = line;
        endcase
    endfunction

    assign index  = addr_i[4 +: `DC_INDEX_BITS];
    assign tag    = addr_i[31 -: `DC_TAG_BITS];
    assign offset = addr_i[3:0];

    assign way_tag  = sram_rentry_i[`DC_ENTRY_BITS-1 -: `DC_TAG_BITS];
    assign way_line = sram_rentry_i[`DC_LINE_BITS-1:0];

    assign hit          = valid_q[index] && (way_tag == tag);
    assign victim_dirty = valid_q[index] && dirty_q[index];

    assign line_addr   = {addr_i[31:4], 4'b0000};
    assign victim_addr = {way_tag, index, 4'b0000};

    // refilled line, with the pending store merged in
    assign fill_line = write_i ? store_merge(mem_rline_i, offset, wdata_i, op_i) : mem_rline_i;

    always_comb begin
        state_d       = state_q;
        sram_en_o     = 1'b0;
        sram_we_o     = 1'b0;
        sram_addr_o   = index;
        sram_wentry_o = {tag, fill_line};
        rdata_o       = 32'd0;
        done_o        = 1'b0;
        mem_req_o     = 1'b0;
        fill_en       = 1'b0;
        store_hit     = 1'b0;

        case (state_q)
            DC_IDLE: begin
                if (read_i || write_i) begin
                    sram_en_o = 1'b1;
                    state_d   = DC_LOOKUP;
                end
            end

            DC_LOOKUP: begin
                if (hit) begin
                    done_o  = 1'b1;
                    state_d = DC_IDLE;
                    if (read_i) begin
                        rdata_o = load_ext(way_line, offset, op_i);
                    end else begin
                        sram_en_o     = 1'b1;
                        sram_we_o     = 1'b1;
                        sram_wentry_o = {tag, store_merge(way_line, offset, wdata_i, op_i)};
                        store_hit     = 1'b1;
                    end
                end else if (mem_free_i) begin
                    mem_req_o = 1'b1;
                    state_d   = victim_dirty ? DC_WRITEBACK : DC_REFILL;
                end else begin
                    // memory busy, keep the entry fresh
                    sram_en_o = 1'b1;
                end
            end

            DC_WRITEBACK: begin
                // refill request goes out in the write-back ready cycle
                if (mem_ready_i) begin
                    mem_req_o = 1'b1;
                    state_d   = DC_REFILL;
                end
            end

            DC_REFILL: begin
                if (mem_ready_i) begin
                    sram_en_o = 1'b1;
                    sram_we_o = 1'b1;
                    fill_en   = 1'b1;
                    done_o    = 1'b1;
                    state_d   = DC_IDLE;
                    if (read_i) begin
                        rdata_o = load_ext(mem_rline_i, offset, op_i);
                    end
                end
            end

            default: state_d = DC_IDLE;
        endcase
    end

    // levels follow the state being entered
    assign mem_wr_o    = (state_d == DC_WRITEBACK);
    assign mem_rd_o    = (state_d == DC_REFILL);
    assign mem_addr_o  = mem_wr_o ? victim_addr : (mem_rd_o ? line_addr : 32'd0);
    assign mem_wline_o = way_line;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= DC_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_en) begin
                valid_q[index] <= 1'b1;
                dirty_q[index] <= write_i;
            end else if (store_hit) begin
                dirty_q[index] <= 1'b1;
            end
        end
    end

    a_one_request: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(read_i && write_i));

    a_req_when_free: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_o |-> mem_free_i);

    a_load_op: assert property (@(posedge clk_i) disable iff (!rst_i)
        read_i |-> (op_i inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}));

    a_store_op: assert property (@(posedge clk_i) disable iff (!rst_i)
        write_i |-> (op_i inside {OP_SB, OP_SH, OP_SW}));

endmodule

// ==== source/line_sram.sv ====
`timescale 1ns/1ns

`include "dcache_config.svh"

module line_sram (
    input  logic                       clk_i,
    input  logic                       en_i,
    input  logic                       we_i,
    input  logic [`DC_INDEX_BITS-1:0]  addr_i,
    input  logic [`DC_ENTRY_BITS-1:0]  wentry_i,
    output logic [`DC_ENTRY_BITS-1:0]  rentry_o
);

    // one tag and one data line per index
    logic [`DC_ENTRY_BITS-1:0] mem_q [`DC_LINES];

    // write has priority, read output holds otherwise
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wentry_i;
            end else begin
                rentry_o <= mem_q[addr_i];
            end
        end
    end

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // cache controller states
    typedef enum logic [1:0] {
        DC_IDLE      = 2'd0,
        DC_LOOKUP    = 2'd1,
        DC_WRITEBACK = 2'd2,
        DC_REFILL    = 2'd3
    } dc_state_e;

    // backing memory controller states
    typedef enum logic [1:0] {
        MM_FREE = 2'd0,
        MM_BUSY = 2'd1,
        MM_DONE = 2'd2
    } mm_state_e;

endpackage

// ==== source/mem_op_pkg.sv ====
package mem_op_pkg;

    // memory stage opcodes, loads first
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

endpackage

// ==== include/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry, direct mapped
`define DC_LINES      128
`define DC_INDEX_BITS 7
`define DC_LINE_BITS  128
`define DC_TAG_BITS   21

// tag on top of the data line
`define DC_ENTRY_BITS 149

// backing memory
`define MM_LINES      4096
`define MM_LATENCY    4

`endif
